// File: common/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry
`define DC_WAY_NUM    2
`define DC_SET_NUM    64
`define DC_LINE_WORDS 4

// pending stores
`define DC_SB_SIZE    4

// address split: word offset, set index, tag
`define DC_OFFSET_LOW 2
`define DC_INDEX_LOW  (`DC_OFFSET_LOW + $clog2(`DC_LINE_WORDS))
`define DC_INDEX_HIGH (`DC_INDEX_LOW + $clog2(`DC_SET_NUM) - 1)
`define DC_TAG_LOW    (`DC_INDEX_HIGH + 1)

`endif

// File: common/dcache_pkg.sv
`include "dcache_consts.svh"

package dcache_pkg;

    typedef struct packed {
        logic                  valid;
        logic [31:`DC_TAG_LOW] tag;
    } tag_entry_t;

    // store when strb is nonzero, load otherwise
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [3:0]  rmask;
        logic [1:0]  size;
        logic        sign;
        logic [3:0]  id;
    } lsu_req_t;

    typedef struct packed {
        logic [3:0]             id;
        logic [31:0]            addr;
        logic [31:0]            rdata;
        logic                   hit;
        logic                   store;
        logic [`DC_WAY_NUM-1:0] hit_way;
    } lsu_resp_t;

    typedef struct packed {
        logic [31:0]            addr;
        logic [31:0]            data;
        logic [3:0]             strb;
        logic [`DC_WAY_NUM-1:0] hit_way;
    } sb_entry_t;

    // forwarding view, slot 0 is the oldest
    typedef struct packed {
        logic [`DC_SB_SIZE-1:0]      vld;
        sb_entry_t [`DC_SB_SIZE-1:0] ent;
    } sb_fwd_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic        last;
    } refill_req_t;

    typedef struct packed {
        logic [`DC_INDEX_HIGH:`DC_INDEX_LOW]    set;
        logic [`DC_INDEX_LOW-1:`DC_OFFSET_LOW] offset;
        logic [3:0]                            strb;
        logic                                  tag_we;
        tag_entry_t                            tag;
        logic [31:0]                           data;
        logic [`DC_WAY_NUM-1:0]                way_en;
    } way_wr_t;

    typedef struct packed {
        logic        hit;
        logic [31:0] data;
    } way_rd_t;

endpackage

// File: dcache_way/dcache_way.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_way (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [`DC_INDEX_HIGH:`DC_OFFSET_LOW] rd_addr_i,
    input  logic [31:`DC_TAG_LOW]                rd_tag_i,
    input  dcache_pkg::way_wr_t                  wr_i,
    input  logic                                 way_en_i,
    output dcache_pkg::way_rd_t                  rd_o
);
    logic [`DC_INDEX_HIGH:`DC_INDEX_LOW] rd_set;
    logic                                tag_we;
    logic                                tag_conflict;
    logic                                data_conflict;
    logic                                tag_conflict_q;
    logic                                data_conflict_q;
    logic [`DC_SET_NUM-1:0]              set_vld;
    logic                                set_vld_q;
    logic [31:`DC_TAG_LOW]               rd_tag_q;
    dcache_pkg::tag_entry_t              tag0;
    dcache_pkg::tag_entry_t              tag1;
    dcache_pkg::tag_entry_t              tag_sel;
    logic [31:0]                         data0;
    logic [31:0]                         data1;

    assign rd_set = rd_addr_i[`DC_INDEX_HIGH:`DC_INDEX_LOW];
    assign tag_we = way_en_i & wr_i.tag_we;

    // port 1 sits on the address being read
    assign tag_conflict  = (wr_i.set == rd_set);
    assign data_conflict = tag_conflict &
                           (wr_i.offset == rd_addr_i[`DC_INDEX_LOW-1:`DC_OFFSET_LOW]);

    dpsram #(
        .T(dcache_pkg::tag_entry_t),
        .LANES(1),
        .DEPTH(`DC_SET_NUM)
    ) tag_ram (
        .clk,
        .rst_n,
        .addr0_i(rd_set),
        .en0_i(!tag_conflict),
        .rdata0_o(tag0),
        .addr1_i(wr_i.set),
        .we1_i(tag_we),
        .wdata1_i(wr_i.tag),
        .rdata1_o(tag1)
    );

    dpsram #(
        .T(logic [31:0]),
        .LANES(4),
        .DEPTH(`DC_SET_NUM * `DC_LINE_WORDS)
    ) data_ram (
        .clk,
        .rst_n,
        .addr0_i(rd_addr_i),
        .en0_i(!data_conflict),
        .rdata0_o(data0),
        .addr1_i({wr_i.set, wr_i.offset}),
        .we1_i({4{way_en_i}} & wr_i.strb),
        .wdata1_i(wr_i.data),
        .rdata1_o(data1)
    );

    // per-set valid bits, the tag RAM itself comes up unknown
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            set_vld         <= '0;
            set_vld_q       <= 1'b0;
            tag_conflict_q  <= 1'b0;
            data_conflict_q <= 1'b0;
        end else begin
            if (tag_we) begin
                set_vld[wr_i.set] <= wr_i.tag.valid;
            end
            set_vld_q       <= (tag_we & tag_conflict) ? wr_i.tag.valid : set_vld[rd_set];
            tag_conflict_q  <= tag_conflict;
            data_conflict_q <= data_conflict;
        end
    end

    always_ff @(posedge clk) begin
        rd_tag_q <= rd_tag_i;
    end

    assign tag_sel    = tag_conflict_q ? tag1 : tag0;
    assign rd_o.hit   = set_vld_q & tag_sel.valid & (tag_sel.tag == rd_tag_q);
    assign rd_o.data  = data_conflict_q ? data1 : data0;

endmodule

// File: files.f
+incdir+common
common/dcache_pkg.sv
source/dpsram.sv
dcache_way/dcache_way.sv
source/dcache_req_decode.sv
store_buffer/store_buffer.sv
source/dcache_write_port.sv
source/dcache_load_merge.sv
source/dcache_top.sv
test/dcache_checker.sv
test/tb_dcache.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dcache -f files.f -o sim_dcache
./obj_dir/sim_dcache 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST OK" sim.log

// File: source/dcache_load_merge.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_load_merge (
    input  dcache_pkg::lsu_req_t                  s1_req_i,
    input  logic                                  s1_valid_i,
    input  dcache_pkg::way_rd_t [`DC_WAY_NUM-1:0] ways_i,
    input  dcache_pkg::sb_fwd_t                   sb_entries_i,
    output dcache_pkg::lsu_resp_t                 resp_o,
    output logic                                  resp_valid_o,
    output logic                                  push_o,
    output dcache_pkg::sb_entry_t                 entry_o
);
    logic [`DC_WAY_NUM-1:0] hit_way;
    logic [31:0]            cache_word;
    logic [31:0]            merged;
    logic [31:0]            shifted;
    logic [31:0]            rdata;
    logic [3:0]             sb_cov;
    logic [3:0]             covered;
    logic                   is_store;

    // at most one way hits
    always_comb begin
        hit_way    = '0;
        cache_word = '0;
        for (int w = 0; w < `DC_WAY_NUM; w++) begin
            hit_way[w] = ways_i[w].hit;
            if (ways_i[w].hit) begin
                cache_word = cache_word | ways_i[w].data;
            end
        end
    end

    // younger entries come later and overwrite
    always_comb begin
        merged = cache_word;
        sb_cov = '0;
        for (int k = 0; k < `DC_SB_SIZE; k++) begin
            for (int b = 0; b < 4; b++) begin
                if (sb_entries_i.vld[k] && sb_entries_i.ent[k].strb[b] &&
                    sb_entries_i.ent[k].addr[31:2] == s1_req_i.addr[31:2]) begin
                    merged[8*b +: 8] = sb_entries_i.ent[k].data[8*b +: 8];
                    sb_cov[b]        = 1'b1;
                end
            end
        end
    end

    assign covered = (|hit_way) ? 4'hf : sb_cov;

    // lowest mask byte lands at bit 0
    always_comb begin
        shifted = merged;
        for (int b = 3; b >= 0; b--) begin
            if (s1_req_i.rmask[b]) begin
                shifted = merged >> (8 * b);
            end
        end
        case (s1_req_i.size)
            2'd0:    rdata = {{24{s1_req_i.sign & shifted[7]}}, shifted[7:0]};
            2'd1:    rdata = {{16{s1_req_i.sign & shifted[15]}}, shifted[15:0]};
            default: rdata = shifted;
        endcase
    end

    assign is_store     = |s1_req_i.strb;
    assign resp_valid_o = s1_valid_i;

    always_comb begin
        resp_o.id      = s1_req_i.id;
        resp_o.addr    = s1_req_i.addr;
        resp_o.rdata   = rdata;
        resp_o.store   = is_store;
        resp_o.hit_way = hit_way;
        // a load hits once every requested byte is covered
        resp_o.hit     = is_store ? |hit_way : ((s1_req_i.rmask & ~covered) == 4'h0);
    end

    assign push_o          = s1_valid_i & is_store;
    assign entry_o.addr    = s1_req_i.addr;
    assign entry_o.data    = s1_req_i.wdata;
    assign entry_o.strb    = s1_req_i.strb;
    assign entry_o.hit_way = hit_way;

endmodule

// File: source/dcache_req_decode.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_req_decode (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 flush_i,
    input  dcache_pkg::lsu_req_t                 req_i,
    input  logic                                 req_valid_i,
    output logic                                 req_ready_o,
    input  logic                                 sb_full_i,
    output logic [`DC_INDEX_HIGH:`DC_OFFSET_LOW] rd_addr_o,
    output logic [31:`DC_TAG_LOW]                rd_tag_o,
    output dcache_pkg::lsu_req_t                 s1_req_o,
    output logic                                 s1_valid_o
);
    logic accept;

    assign req_ready_o = ~sb_full_i & ~flush_i;
    assign accept      = req_valid_i & req_ready_o;

    // ways are read straight from the incoming address
    assign rd_addr_o = req_i.addr[`DC_INDEX_HIGH:`DC_OFFSET_LOW];
    assign rd_tag_o  = req_i.addr[31:`DC_TAG_LOW];

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_req_o <= req_i;
        end
    end

endmodule

// File: source/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush_i,
    input  dcache_pkg::lsu_req_t    req_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    output dcache_pkg::lsu_resp_t   resp_o,
    output logic                    resp_valid_o,
    input  logic                    refill_valid_i,
    input  dcache_pkg::refill_req_t refill_i,
    input  logic                    commit_i,
    output logic                    sb_empty_o
);
    logic [`DC_INDEX_HIGH:`DC_OFFSET_LOW]  rd_addr;
    logic [31:`DC_TAG_LOW]                 rd_tag;
    dcache_pkg::lsu_req_t                  s1_req;
    logic                                  s1_valid;
    logic                                  s1_live;
    dcache_pkg::way_rd_t [`DC_WAY_NUM-1:0] way_rd;
    dcache_pkg::way_wr_t                   way_wr;
    dcache_pkg::sb_fwd_t                   sb_fwd;
    dcache_pkg::sb_entry_t                 sb_push_entry;
    dcache_pkg::sb_entry_t                 sb_head;
    logic                                  sb_push;
    logic                                  sb_pop;
    logic                                  sb_full;

    dcache_req_decode u_decode (
        .clk,
        .rst_n,
        .flush_i,
        .req_i,
        .req_valid_i,
        .req_ready_o,
        .sb_full_i(sb_full),
        .rd_addr_o(rd_addr),
        .rd_tag_o(rd_tag),
        .s1_req_o(s1_req),
        .s1_valid_o(s1_valid)
    );

    // flush kills whatever sits in stage 1
    assign s1_live = s1_valid & ~flush_i;

    for (genvar i = 0; i < `DC_WAY_NUM; i++) begin : g_way
        dcache_way u_way (
            .clk,
            .rst_n,
            .rd_addr_i(rd_addr),
            .rd_tag_i(rd_tag),
            .wr_i(way_wr),
            .way_en_i(way_wr.way_en[i]),
            .rd_o(way_rd[i])
        );
    end

    dcache_load_merge u_merge (
        .s1_req_i(s1_req),
        .s1_valid_i(s1_live),
        .ways_i(way_rd),
        .sb_entries_i(sb_fwd),
        .resp_o,
        .resp_valid_o,
        .push_o(sb_push),
        .entry_o(sb_push_entry)
    );

    store_buffer u_sb (
        .clk,
        .rst_n,
        .flush_i,
        .push_i(sb_push),
        .entry_i(sb_push_entry),
        .pop_i(sb_pop),
        .head_o(sb_head),
        .entries_o(sb_fwd),
        .full_o(sb_full),
        .empty_o(sb_empty_o)
    );

    dcache_write_port u_wport (
        .clk,
        .rst_n,
        .refill_valid_i,
        .refill_i,
        .commit_i,
        .sb_empty_i(sb_empty_o),
        .head_i(sb_head),
        .pop_o(sb_pop),
        .wr_o(way_wr)
    );

endmodule

// File: source/dcache_write_port.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_write_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    refill_valid_i,
    input  dcache_pkg::refill_req_t refill_i,
    input  logic                    commit_i,
    input  logic                    sb_empty_i,
    input  dcache_pkg::sb_entry_t   head_i,
    output logic                    pop_o,
    output dcache_pkg::way_wr_t     wr_o
);
    localparam int VW = $clog2(`DC_WAY_NUM);

    logic [VW-1:0]         victim;
    dcache_pkg::sb_entry_t hold;
    logic                  hold_vld;
    logic                  drain;

    // refill owns the port, a held store waits
    assign drain = hold_vld & ~refill_valid_i;
    assign pop_o = commit_i & ~sb_empty_i & (~hold_vld | drain);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            victim   <= '0;
            hold_vld <= 1'b0;
        end else begin
            if (refill_valid_i && refill_i.last) begin
                victim <= victim + 1'b1;
            end
            // missed stores are dropped here
            if (pop_o) begin
                hold_vld <= |head_i.hit_way;
            end else if (drain) begin
                hold_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            hold <= head_i;
        end
    end

    always_comb begin
        wr_o = '0;
        if (refill_valid_i) begin
            wr_o.set            = refill_i.addr[`DC_INDEX_HIGH:`DC_INDEX_LOW];
            wr_o.offset         = refill_i.addr[`DC_INDEX_LOW-1:`DC_OFFSET_LOW];
            wr_o.strb           = 4'hf;
            wr_o.tag_we         = 1'b1;
            wr_o.tag.valid      = 1'b1;
            wr_o.tag.tag        = refill_i.addr[31:`DC_TAG_LOW];
            wr_o.data           = refill_i.data;
            wr_o.way_en[victim] = 1'b1;
        end else begin
            wr_o.set    = hold.addr[`DC_INDEX_HIGH:`DC_INDEX_LOW];
            wr_o.offset = hold.addr[`DC_INDEX_LOW-1:`DC_OFFSET_LOW];
            wr_o.strb   = hold.strb;
            wr_o.data   = hold.data;
            wr_o.way_en = drain ? hold.hit_way : '0;
        end
    end

endmodule

// File: source/dpsram.sv
`timescale 1ns/1ps

module dpsram #(
    parameter type T     = logic [31:0],
    parameter int  LANES = 4,
    parameter int  DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [$clog2(DEPTH)-1:0] addr0_i,
    input  logic                     en0_i,
    output T                         rdata0_o,
    input  logic [$clog2(DEPTH)-1:0] addr1_i,
    input  logic [LANES-1:0]         we1_i,
    input  T                         wdata1_i,
    output T                         rdata1_o
);
    localparam int W  = $bits(T);
    localparam int LW = W / LANES;

    logic [W-1:0] mem [DEPTH];
    logic [W-1:0] wdata;
    logic [W-1:0] merged;

    assign wdata = wdata1_i;

    // old word with the written lanes replaced
    always_comb begin
        merged = mem[addr1_i];
        for (int l = 0; l < LANES; l++) begin
            if (we1_i[l]) begin
                merged[l*LW +: LW] = wdata[l*LW +: LW];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|we1_i) begin
            mem[addr1_i] <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata0_o <= '0;
            rdata1_o <= '0;
        end else begin
            if (en0_i) begin
                rdata0_o <= mem[addr0_i];
            end
            // write-first readback
            rdata1_o <= merged;
        end
    end

endmodule

// File: store_buffer/store_buffer.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module store_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  flush_i,
    input  logic                  push_i,
    input  dcache_pkg::sb_entry_t entry_i,
    input  logic                  pop_i,
    output dcache_pkg::sb_entry_t head_o,
    output dcache_pkg::sb_fwd_t   entries_o,
    output logic                  full_o,
    output logic                  empty_o
);
    localparam int PW = $clog2(`DC_SB_SIZE);

    dcache_pkg::sb_entry_t  slots [`DC_SB_SIZE];
    logic [`DC_SB_SIZE-1:0] slot_vld;
    logic [PW-1:0]          head;
    logic [PW-1:0]          tail;
    logic [PW-1:0]          tail_nxt;
    logic [PW-1:0]          start;
    logic                   pop_ok;
    logic                   drain_q;

    assign tail_nxt = tail + 1'b1;
    assign pop_ok   = pop_i & slot_vld[head];
    assign head_o   = slots[head];
    assign empty_o  = ~|slot_vld;
    // last free slot with a store landing this edge counts as full
    assign full_o   = slot_vld[tail] | (push_i & slot_vld[tail_nxt]);

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            slot_vld <= '0;
            head     <= '0;
            tail     <= '0;
            drain_q  <= 1'b0;
        end else begin
            // popped hit stays visible until the write port stores it
            drain_q <= pop_ok & (|slots[head].hit_way);
            if (push_i) begin
                slot_vld[tail] <= 1'b1;
                tail           <= tail_nxt;
            end
            if (pop_ok) begin
                slot_vld[head] <= 1'b0;
                head           <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            slots[tail] <= entry_i;
        end
    end

    assign start = drain_q ? head - 1'b1 : head;

    // oldest first, so the merge lets younger stores win
    always_comb begin
        logic [PW-1:0] idx;
        for (int k = 0; k < `DC_SB_SIZE; k++) begin
            idx              = start + PW'(k);
            entries_o.ent[k] = slots[idx];
            entries_o.vld[k] = slot_vld[idx] | (drain_q && k == 0);
        end
    end

endmodule

// File: test/dcache_checker.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_checker (
    input logic clk,
    input logic rst_n,
    input logic flush_i,
    input logic req_valid_i,
    input logic req_ready_o,
    input logic resp_valid_o,
    input logic sb_push_i,
    input logic sb_pop_i,
    input logic sb_empty_i
);
    // stores held in the buffer, counted from its push and pop strobes
    int held;

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            held <= 0;
        end else begin
            held <= held + (sb_push_i ? 1 : 0) - (sb_pop_i ? 1 : 0);
        end
    end

    // every response belongs to a request accepted one edge earlier
    a_resp_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o |-> $past(req_valid_i && req_ready_o))
        else $error("response without an accepted request");

    a_full_holds_req: assert property (@(posedge clk) disable iff (!rst_n)
        held == `DC_SB_SIZE |-> !req_ready_o)
        else $error("request ready while the store buffer is full");

    a_flush_kills_resp: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> !resp_valid_o && sb_empty_i)
        else $error("response or pending store in the cycle after a flush");

endmodule

bind dcache_top dcache_checker u_checker (
    .clk(clk),
    .rst_n(rst_n),
    .flush_i(flush_i),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .resp_valid_o(resp_valid_o),
    .sb_push_i(sb_push),
    .sb_pop_i(sb_pop),
    .sb_empty_i(sb_empty_o)
);

// File: test/dcache_testdata.txt
# columns in hex: R addr data last | S addr data strb | L addr mask size sign hit data
# C drains the store buffer | F ready_before_flush | W idle_cycles
W 3
# refill one line, then hits and a miss
R 00001000 11223344 0
R 00001004 55667788 0
R 00001008 99aabbcc 0
R 0000100c 8090a0b0 1
L 00001000 f 2 0 1 11223344
L 00001004 f 2 0 1 55667788
L 0000100c f 2 0 1 8090a0b0
L 00002040 f 2 0 0 00000000
# two more lines in set 0 evict the first
R 00002000 aaaa0000 1
R 00003000 bbbb0000 1
L 00001000 f 2 0 0 00000000
L 00002000 f 2 0 1 aaaa0000
L 00003000 f 2 0 1 bbbb0000
# forwarding from the store buffer
R 00004010 01020304 0
R 00004014 f0e0d0c0 0
R 00004018 7f8f9faf 0
R 0000401c 00000000 1
S 00004010 aabbccdd 3
L 00004010 f 2 0 1 0102ccdd
S 00004010 11223344 2
L 00004010 f 2 0 1 010233dd
S 00005020 deadbeef f
L 00005020 f 2 0 1 deadbeef
# drain to the cache, the missed store is dropped
C
L 00004010 f 2 0 1 010233dd
L 00005020 f 2 0 0 00000000
# byte and half loads
L 00004014 1 0 0 1 000000c0
L 00004015 2 0 1 1 ffffffd0
L 00004016 c 1 1 1 fffff0e0
L 00004014 3 1 0 1 0000d0c0
L 00004018 1 0 1 1 ffffffaf
L 0000401b 8 0 1 1 0000007f
# fill the store buffer, then flush it
S 00004018 00000055 1
S 0000401c 12345678 f
S 00004010 ffffffff f
S 00004014 00000000 f
F 0
L 00004018 f 2 0 1 7f8f9faf
L 00004010 f 2 0 1 010233dd
L 0000401c f 2 0 1 00000000

// File: test/tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module tb_dcache;

    // one line of the test data file
    typedef struct packed {
        logic [7:0]  op;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        logic [31:0] a4;
        logic [31:0] a5;
    } test_op_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    flush_i;
    dcache_pkg::lsu_req_t    req_i;
    logic                    req_valid_i;
    logic                    req_ready_o;
    dcache_pkg::lsu_resp_t   resp_o;
    logic                    resp_valid_o;
    logic                    refill_valid_i;
    dcache_pkg::refill_req_t refill_i;
    logic                    commit_i;
    logic                    sb_empty_o;

    test_op_t    ops[$];
    int unsigned seed    = 32'hd2df90f6;
    int          errors  = 0;
    int          checks  = 0;
    bit          loaded  = 1'b0;
    logic [3:0]  next_id = 4'd0;

    // tags each way should hold, filled by the refills
    logic [31:`DC_TAG_LOW] model_tag [`DC_WAY_NUM][`DC_SET_NUM];
    bit                    model_vld [`DC_WAY_NUM][`DC_SET_NUM];
    int                    victim_way = 0;

    dcache_top dut0 (
        .clk,
        .rst_n,
        .flush_i,
        .req_i,
        .req_valid_i,
        .req_ready_o,
        .resp_o,
        .resp_valid_o,
        .refill_valid_i,
        .refill_i,
        .commit_i,
        .sb_empty_o
    );

    always #5 clk = ~clk;

    function int unsigned lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [`DC_WAY_NUM-1:0] tag_match_ways(input logic [31:0] addr);
        logic [`DC_WAY_NUM-1:0] ways;
        int                     set_idx;
        ways    = '0;
        set_idx = int'(addr[`DC_INDEX_HIGH:`DC_INDEX_LOW]);
        for (int w = 0; w < `DC_WAY_NUM; w++) begin
            ways[w] = model_vld[w][set_idx] &&
                      (model_tag[w][set_idx] == addr[31:`DC_TAG_LOW]);
        end
        return ways;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic load_ops();
        int       fd;
        int       n;
        string    line;
        test_op_t t;
        fd = $fopen("test/dcache_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/dcache_testdata.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0) begin
                t = '0;
                t.op = line.getc(0);
                // comments and blank lines start with no opcode letter
                if (t.op >= "A" && t.op <= "Z") begin
                    n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
                                t.a0, t.a1, t.a2, t.a3, t.a4, t.a5);
                    ops.push_back(t);
                end
            end
        end
        $fclose(fd);
        if (ops.size() == 0) begin
            $display("no operations found in the test data file");
            errors++;
        end
    endtask

    // holds the request until accepted, then samples stage 1 mid-cycle
    task automatic send_req(input dcache_pkg::lsu_req_t req,
                            output dcache_pkg::lsu_resp_t resp, output logic got);
        logic accepted;
        req_i       = req;
        req_valid_i = 1'b1;
        accepted    = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = req_ready_o;
            @(posedge clk);
        end
        #1;
        req_valid_i = 1'b0;
        next_id     = next_id + 4'd1;
        @(negedge clk);
        got  = resp_valid_o;
        resp = resp_o;
        @(posedge clk);
        #1;
    endtask

    task automatic run_op(input test_op_t t);
        dcache_pkg::lsu_req_t   req;
        dcache_pkg::lsu_resp_t  resp;
        logic                   got;
        int                     n;
        int                     set_idx;
        logic [`DC_WAY_NUM-1:0] exp_ways;
        req      = '0;
        req.addr = t.a0;
        req.id   = next_id;
        case (t.op)
            "R": begin
                // the refill lands in the victim way, which moves on after the last word
                set_idx = int'(t.a0[`DC_INDEX_HIGH:`DC_INDEX_LOW]);
                model_vld[victim_way][set_idx] = 1'b1;
                model_tag[victim_way][set_idx] = t.a0[31:`DC_TAG_LOW];
                if (t.a2[0]) begin
                    victim_way = (victim_way + 1) % `DC_WAY_NUM;
                end
                refill_i.addr  = t.a0;
                refill_i.data  = t.a1;
                refill_i.last  = t.a2[0];
                refill_valid_i = 1'b1;
                @(posedge clk);
                #1;
                refill_valid_i = 1'b0;
            end
            "S": begin
                req.wdata = t.a1;
                req.strb  = t.a2[3:0];
                exp_ways  = tag_match_ways(t.a0);
                send_req(req, resp, got);
                check_eq("store response valid", 32'(got), 32'd1);
                check_eq("store id", 32'(resp.id), 32'(req.id));
                check_eq("store address", resp.addr, t.a0);
                check_eq("store flag", 32'(resp.store), 32'd1);
                check_eq("store hit", 32'(resp.hit), 32'(|exp_ways));
                check_eq("store hit way", 32'(resp.hit_way), 32'(exp_ways));
            end
            "L": begin
                req.rmask = t.a1[3:0];
                req.size  = t.a2[1:0];
                req.sign  = t.a3[0];
                exp_ways  = tag_match_ways(t.a0);
                send_req(req, resp, got);
                check_eq("load response valid", 32'(got), 32'd1);
                check_eq("load id", 32'(resp.id), 32'(req.id));
                check_eq("load address", resp.addr, t.a0);
                check_eq("load flag", 32'(resp.store), 32'd0);
                check_eq("load hit", 32'(resp.hit), 32'(t.a4[0]));
                check_eq("load hit way", 32'(resp.hit_way), 32'(exp_ways));
                // data of a miss is undefined
                if (t.a4[0]) begin
                    check_eq("load data", resp.rdata, t.a5);
                end
            end
            "C": begin
                n = 0;
                while (!sb_empty_o && n < 16) begin
                    commit_i = 1'b1;
                    @(posedge clk);
                    #1;
                    commit_i = 1'b0;
                    n++;
                end
                // last popped store reaches the RAM one edge later
                @(posedge clk);
                #1;
                check_eq("store buffer empty after commits", 32'(sb_empty_o), 32'd1);
            end
            "F": begin
                check_eq("ready before flush", 32'(req_ready_o), t.a0);
                flush_i = 1'b1;
                @(posedge clk);
                #1;
                flush_i = 1'b0;
                check_eq("store buffer empty after flush", 32'(sb_empty_o), 32'd1);
            end
            "W": begin
                repeat (t.a0) begin
                    @(posedge clk);
                    #1;
                end
            end
            default: begin
                errors++;
                $display("unknown opcode %c in the test data file", t.op);
            end
        endcase
    endtask

    initial begin
        int idle;
        rst_n          = 1'b0;
        flush_i        = 1'b0;
        req_i          = '0;
        req_valid_i    = 1'b0;
        refill_valid_i = 1'b0;
        refill_i       = '0;
        commit_i       = 1'b0;
        load_ops();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (ops[i]) begin
            idle = int'((lcg_next() >> 16) % 3);
            repeat (idle) begin
                @(posedge clk);
                #1;
            end
            run_op(ops[i]);
        end
        repeat (4) @(posedge clk);
        $display("tb_dcache: %0d operations, %0d checks, %0d errors",
                 ops.size(), checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // 20 cycles per operation plus a margin
    initial begin
        longint limit;
        wait (loaded);
        limit = longint'(ops.size()) * 20 * 10 + 1000;
        #(limit);
        $display("watchdog: the test did not finish within %0d ns", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule
